// ==== rtl/pkt_stream_pkg.sv ====
`default_nettype none

// Beat layout for the padded byte stream, AXI4-Stream style
package pkt_stream_pkg;

    // ==========================================================================
    // Stream widths
    // ==========================================================================
    localparam int DATA_BYTE_WID = 8;
    localparam int TID_WID       = 4;
    localparam int TDEST_WID     = 4;
    localparam int TUSER_WID     = 8;

    // ==========================================================================
    // Beat struct
    // ==========================================================================
    // Byte 0 sits in the low bits of tdata
    // tkeep is contiguous from bit 0, one bit per byte
    typedef struct packed {
        logic [DATA_BYTE_WID-1:0][7:0] tdata;
        logic [DATA_BYTE_WID-1:0]      tkeep;
        logic                          tlast;
        logic [TID_WID-1:0]            tid;
        logic [TDEST_WID-1:0]          tdest;
        logic [TUSER_WID-1:0]          tuser;
    } axis_beat_t;

endpackage

`default_nettype wire

// ==== rtl/credit_pkg.sv ====
`default_nettype none

// Credit accounting shared by the input and output boundaries
package credit_pkg;

    // Unsigned count of credits held by one side of a boundary
    typedef logic [7:0] credit_cnt_t;

    // Largest count a boundary may ever hold
    localparam credit_cnt_t CREDIT_MAX = 8'd255;

endpackage

`default_nettype wire

// ==== rtl/pkt_ingress_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_ingress_buffer
    import pkt_stream_pkg::*;
    import credit_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  axis_beat_t in_beat,
    output logic       in_credit,
    output logic       buf_valid,
    output axis_beat_t buf_beat,
    input  logic       buf_ready
);

    localparam int                 PTR_WID   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_WID-1:0] LAST_PTR  = PTR_WID'(FIFO_DEPTH - 1);
    localparam credit_cnt_t        DEPTH_CNT = credit_cnt_t'(FIFO_DEPTH);

    axis_beat_t         mem [FIFO_DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    credit_cnt_t        count;
    logic               full;
    logic               wr_en;
    logic               rd_en;

    assign full  = (count == DEPTH_CNT);
    assign wr_en = in_valid && !full;
    assign rd_en = buf_valid && buf_ready;

    // Show-ahead read side
    assign buf_valid = (count != '0);
    assign buf_beat  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // ==========================================================================
    // Pointers, occupancy and credit return
    // ==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per freed entry
            in_credit <= rd_en;
        end
    end

    // Sender may only push while it holds a credit, so a full FIFO never sees one
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !full);

endmodule

`default_nettype wire

// ==== rtl/pkt_pad.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_pad
    import pkt_stream_pkg::*;
#(
    parameter int MIN_PKT_SIZE = 60
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       buf_valid,
    input  axis_beat_t buf_beat,
    output logic       buf_ready,
    output logic       pad_valid,
    output axis_beat_t pad_beat,
    input  logic       pad_ready
);

    localparam int                 CNT_WID  = $clog2(MIN_PKT_SIZE + DATA_BYTE_WID + 1);
    localparam logic [CNT_WID-1:0] MIN_CNT  = CNT_WID'(MIN_PKT_SIZE);
    localparam logic [CNT_WID-1:0] BEAT_CNT = CNT_WID'(DATA_BYTE_WID);

    typedef enum logic {
        ST_PASS,
        ST_PAD
    } pad_state_t;

    pad_state_t           state;
    logic [CNT_WID-1:0]   byte_cnt;    // saturates at MIN_CNT
    logic [CNT_WID-1:0]   rem_cnt;     // pad bytes still to emit
    logic [TID_WID-1:0]   saved_tid;
    logic [TDEST_WID-1:0] saved_tdest;
    logic [TUSER_WID-1:0] saved_tuser;

    logic [CNT_WID-1:0]   beat_bytes;
    logic [CNT_WID-1:0]   byte_sum;
    logic [CNT_WID-1:0]   fill_bytes;
    logic                 short_last;
    logic                 fill_ends;
    logic                 in_xfer;
    logic                 out_xfer;

    function automatic logic [DATA_BYTE_WID-1:0] keep_mask(input logic [CNT_WID-1:0] n);
        logic [DATA_BYTE_WID-1:0] mask;
        for (int i = 0; i < DATA_BYTE_WID; i++) begin
            mask[i] = (CNT_WID'(i) < n);
        end
        return mask;
    endfunction

    function automatic logic [CNT_WID-1:0] keep_count(input logic [DATA_BYTE_WID-1:0] keep);
        logic [CNT_WID-1:0] n;
        n = '0;
        for (int i = 0; i < DATA_BYTE_WID; i++) begin
            n = n + CNT_WID'(keep[i]);
        end
        return n;
    endfunction

    // ==========================================================================
    // Length tracking
    // ==========================================================================
    always_comb begin
        beat_bytes = keep_count(buf_beat.tkeep);
        byte_sum   = byte_cnt + beat_bytes;
        short_last = buf_beat.tlast && (byte_sum < MIN_CNT);
        // Does zero-filling this beat already reach the minimum
        fill_ends  = (byte_cnt + BEAT_CNT) >= MIN_CNT;
        fill_bytes = fill_ends ? (MIN_CNT - byte_cnt) : BEAT_CNT;
    end

    // ==========================================================================
    // Output beat select
    // ==========================================================================
    always_comb begin
        pad_beat  = buf_beat;
        pad_valid = buf_valid;
        buf_ready = pad_ready;
        if (state == ST_PAD) begin
            pad_valid      = 1'b1;
            buf_ready      = 1'b0;
            pad_beat.tdata = '0;
            pad_beat.tkeep = keep_mask((rem_cnt > BEAT_CNT) ? BEAT_CNT : rem_cnt);
            pad_beat.tlast = (rem_cnt <= BEAT_CNT);
            pad_beat.tid   = saved_tid;
            pad_beat.tdest = saved_tdest;
            pad_beat.tuser = saved_tuser;
        end else if (short_last) begin
            // Zero the unused high bytes and mark them valid
            for (int i = 0; i < DATA_BYTE_WID; i++) begin
                if (!buf_beat.tkeep[i]) begin
                    pad_beat.tdata[i] = 8'h00;
                end
            end
            pad_beat.tkeep = keep_mask(fill_bytes);
            pad_beat.tlast = fill_ends;
        end
    end

    assign in_xfer  = buf_valid && buf_ready;
    assign out_xfer = pad_valid && pad_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_PASS;
            byte_cnt <= '0;
            rem_cnt  <= '0;
        end else if (state == ST_PAD) begin
            if (out_xfer) begin
                if (rem_cnt <= BEAT_CNT) begin
                    state   <= ST_PASS;
                    rem_cnt <= '0;
                end else begin
                    rem_cnt <= rem_cnt - BEAT_CNT;
                end
            end
        end else if (in_xfer) begin
            if (!buf_beat.tlast) begin
                byte_cnt <= (byte_sum >= MIN_CNT) ? MIN_CNT : byte_sum;
            end else begin
                byte_cnt <= '0;
                if (short_last && !fill_ends) begin
                    state   <= ST_PAD;
                    rem_cnt <= MIN_CNT - byte_cnt - BEAT_CNT;
                end
            end
        end
    end

    // Metadata carried onto the generated beats
    always_ff @(posedge clk) begin
        if (in_xfer && buf_beat.tlast) begin
            saved_tid   <= buf_beat.tid;
            saved_tdest <= buf_beat.tdest;
            saved_tuser <= buf_beat.tuser;
        end
    end

    // Upstream must present low-order contiguous bytes, never an empty beat
    a_keep_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        in_xfer |-> (buf_beat.tkeep != '0) &&
                    ((buf_beat.tkeep & (buf_beat.tkeep + 1'b1)) == '0));

endmodule

`default_nettype wire

// ==== rtl/pkt_egress_credit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_egress_credit
    import pkt_stream_pkg::*;
    import credit_pkg::*;
#(
    parameter credit_cnt_t OUT_CREDITS = 8'd4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pad_valid,
    input  axis_beat_t pad_beat,
    output logic       pad_ready,
    output logic       out_valid,
    output axis_beat_t out_beat,
    input  logic       out_credit
);

    credit_cnt_t credit_cnt;
    credit_cnt_t credit_avail;
    logic        load;

    // A beat in the register always leaves this cycle, so its credit is already gone
    assign credit_avail = credit_cnt - credit_cnt_t'(out_valid);
    assign pad_ready    = (credit_avail != '0);
    assign load         = pad_valid && pad_ready;

    // ==========================================================================
    // Output register and credit counter
    // ==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            credit_cnt <= OUT_CREDITS;
        end else begin
            out_valid  <= load;
            credit_cnt <= credit_avail + credit_cnt_t'(out_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_beat <= pad_beat;
        end
    end

    // Downstream returns no more credits than were spent
    a_credit_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (credit_cnt == CREDIT_MAX) && !out_valid |-> !out_credit);

    // Each send is covered by a credit held in that cycle
    a_credit_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (credit_cnt != '0));

endmodule

`default_nettype wire

// ==== rtl/pkt_pad_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_pad_top
    import pkt_stream_pkg::*;
    import credit_pkg::*;
#(
    parameter int          MIN_PKT_SIZE = 60,
    parameter credit_cnt_t FIFO_DEPTH   = 8'd8,
    parameter credit_cnt_t OUT_CREDITS  = 8'd4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  axis_beat_t in_beat,
    output logic       in_credit,
    output logic       out_valid,
    output axis_beat_t out_beat,
    input  logic       out_credit
);

    // Ingress to pad
    logic       buf_valid;
    logic       buf_ready;
    axis_beat_t buf_beat;

    // Pad to egress
    logic       pad_valid;
    logic       pad_ready;
    axis_beat_t pad_beat;

    pkt_ingress_buffer #(
        .FIFO_DEPTH (int'(FIFO_DEPTH))
    ) u_ingress (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_credit (in_credit),
        .buf_valid (buf_valid),
        .buf_beat  (buf_beat),
        .buf_ready (buf_ready)
    );

    pkt_pad #(
        .MIN_PKT_SIZE (MIN_PKT_SIZE)
    ) u_pad (
        .clk       (clk),
        .rst_n     (rst_n),
        .buf_valid (buf_valid),
        .buf_beat  (buf_beat),
        .buf_ready (buf_ready),
        .pad_valid (pad_valid),
        .pad_beat  (pad_beat),
        .pad_ready (pad_ready)
    );

    pkt_egress_credit #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_egress (
        .clk        (clk),
        .rst_n      (rst_n),
        .pad_valid  (pad_valid),
        .pad_beat   (pad_beat),
        .pad_ready  (pad_ready),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_credit (out_credit)
    );

endmodule

`default_nettype wire

// ==== verification/tb_pkt_pad_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_pad_top
    import pkt_stream_pkg::*;
    import credit_pkg::*;
();

    localparam int MIN_PKT_SIZE = 60;
    localparam int FIFO_DEPTH   = 8;
    localparam int OUT_CREDITS  = 4;

    // Longest wait for a returned input credit, well above the output stall
    localparam int CREDIT_WAIT_MAX = 200;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    axis_beat_t  in_beat;
    logic        in_credit;
    logic        out_valid;
    axis_beat_t  out_beat;
    logic        out_credit;

    integer      seed = 32'hd0b7_2546;
    int          short_lens[5] = '{1, 7, 8, 33, 59};
    int          stall_lens[3] = '{20, 100, 61};
    logic [7:0]  pkt_bytes[$];
    axis_beat_t  exp_q[$];
    axis_beat_t  got_q[$];
    credit_cnt_t in_credits = credit_cnt_t'(FIFO_DEPTH);
    int          credit_pulses = 0;
    int          beats_sent = 0;
    int          owed = 0;
    int          returned = 0;
    int          out_cycles = 0;
    int          hold_cnt = 0;
    int          errors = 0;
    int          test_passes = 0;
    int          test_fails = 0;

    pkt_pad_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_credit (out_credit)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ========================================================================
    // Upstream credit return and downstream sink
    // ========================================================================
    always @(posedge clk) begin
        if (rst_n && in_credit) begin
            in_credits++;
            credit_pulses++;
            assert (in_credits <= FIFO_DEPTH) else begin
                $display("Error: time %0t, in_credits expected at most %0d, got %0d",
                         $time, FIFO_DEPTH, in_credits);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            got_q.push_back(out_beat);
            out_cycles++;
            owed++;
            assert (out_cycles <= OUT_CREDITS + returned) else begin
                $display("Error: time %0t, out_valid cycles expected at most %0d, got %0d",
                         $time, OUT_CREDITS + returned, out_cycles);
                errors++;
            end
        end
        #1;
        // One credit back per cycle once the hold time is over
        if (rst_n && hold_cnt == 0 && owed > 0) begin
            out_credit = 1'b1;
            owed--;
            returned++;
        end else begin
            out_credit = 1'b0;
        end
        if (hold_cnt > 0) begin
            hold_cnt--;
        end
    end

    function automatic int out_beats(input int len);
        return ((len < MIN_PKT_SIZE ? MIN_PKT_SIZE : len) + DATA_BYTE_WID - 1) / DATA_BYTE_WID;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("Error: time %0t, %s expected %0h, got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) begin
            test_passes++;
            $display("%s: passed", name);
        end else begin
            test_fails++;
            $display("%s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    // Expected output: input bytes, zero fill to the minimum, 8-byte beats
    task automatic model_packet(input logic [3:0] id, input logic [3:0] dest,
                                input logic [7:0] user);
        logic [7:0] bytes_exp[$];
        axis_beat_t b;
        int         n;
        bytes_exp = pkt_bytes;
        while (bytes_exp.size() < MIN_PKT_SIZE) begin
            bytes_exp.push_back(8'h00);
        end
        n = bytes_exp.size();
        for (int i = 0; i < n; i += DATA_BYTE_WID) begin
            b = '0;
            for (int k = 0; k < DATA_BYTE_WID; k++) begin
                if (i + k < n) begin
                    b.tdata[k] = bytes_exp[i + k];
                    b.tkeep[k] = 1'b1;
                end
            end
            b.tlast = (i + DATA_BYTE_WID >= n);
            b.tid   = id;
            b.tdest = dest;
            b.tuser = user;
            exp_q.push_back(b);
        end
    endtask

    task automatic send_beat(input axis_beat_t b);
        int waited;
        waited = 0;
        while (in_credits == 0 && waited < CREDIT_WAIT_MAX) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (in_credits != 0) else begin
            $display("Sender still held no input credit after waiting %0d cycles", waited);
            errors++;
        end
        if (in_credits != 0) begin
            in_valid = 1'b1;
            in_beat  = b;
            in_credits--;
            beats_sent++;
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    task automatic send_packet(input int len);
        axis_beat_t b;
        logic [3:0] id;
        logic [3:0] dest;
        logic [7:0] user;
        id   = 4'($random(seed));
        dest = 4'($random(seed));
        user = 8'($random(seed));
        pkt_bytes.delete();
        for (int i = 0; i < len; i++) begin
            pkt_bytes.push_back(8'($random(seed)));
        end
        model_packet(id, dest, user);
        for (int i = 0; i < len; i += DATA_BYTE_WID) begin
            b = '0;
            for (int k = 0; k < DATA_BYTE_WID; k++) begin
                if (i + k < len) begin
                    b.tdata[k] = pkt_bytes[i + k];
                    b.tkeep[k] = 1'b1;
                end
            end
            b.tlast = (i + DATA_BYTE_WID >= len);
            b.tid   = id;
            b.tdest = dest;
            b.tuser = user;
            send_beat(b);
        end
    endtask

    task automatic compare_output(output int pkts);
        axis_beat_t e;
        axis_beat_t g;
        pkts = 0;
        while (got_q.size() < exp_q.size()) begin
            @(posedge clk);
        end
        // A few idle cycles to catch any extra beat
        repeat (4) @(posedge clk);
        #1;
        check_val("output beat count", exp_q.size(), got_q.size());
        while (exp_q.size() > 0 && got_q.size() > 0) begin
            e = exp_q.pop_front();
            g = got_q.pop_front();
            check_val("out_beat.tdata", e.tdata, g.tdata);
            check_val("out_beat.tkeep", e.tkeep, g.tkeep);
            check_val("out_beat.tlast", e.tlast, g.tlast);
            check_val("out_beat.tid", e.tid, g.tid);
            check_val("out_beat.tdest", e.tdest, g.tdest);
            check_val("out_beat.tuser", e.tuser, g.tuser);
            if (g.tlast) begin
                pkts++;
            end
        end
        exp_q.delete();
        got_q.delete();
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================
    task automatic check_reset();
        int err0;
        err0  = errors;
        rst_n = 1'b0;
        repeat (5) begin
            @(posedge clk);
            #1;
            check_val("out_valid", 0, out_valid);
            check_val("in_credit", 0, in_credit);
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_val("out_valid", 0, out_valid);
        check_val("in_credit", 0, in_credit);
        end_test("reset", err0);
    endtask

    task automatic pass_64_byte_packet();
        int err0;
        int pkts;
        err0 = errors;
        send_packet(64);
        compare_output(pkts);
        check_val("packet count", 1, pkts);
        end_test("64-byte packet", err0);
    endtask

    task automatic pad_short_packets();
        int err0;
        int pkts;
        err0 = errors;
        foreach (short_lens[i]) begin
            send_packet(short_lens[i]);
        end
        compare_output(pkts);
        check_val("packet count", 5, pkts);
        end_test("short packets", err0);
    endtask

    task automatic sweep_lengths();
        int err0;
        int pkts;
        err0 = errors;
        for (int len = 1; len <= 130; len++) begin
            send_packet(len);
        end
        compare_output(pkts);
        check_val("packet count", 130, pkts);
        end_test("length sweep", err0);
    endtask

    task automatic stall_output();
        int err0;
        int pkts;
        err0     = errors;
        hold_cnt = 40;
        foreach (stall_lens[i]) begin
            send_packet(stall_lens[i]);
        end
        compare_output(pkts);
        check_val("packet count", 3, pkts);
        end_test("output back-pressure", err0);
    endtask

    task automatic count_input_credits();
        int err0;
        err0 = errors;
        repeat (4) @(posedge clk);
        #1;
        check_val("in_credit pulses", beats_sent, credit_pulses);
        check_val("sender credits", FIFO_DEPTH, in_credits);
        end_test("input credits", err0);
    endtask

    // Watchdog sized from the output beats of every test
    initial begin
        longint total_beats;
        total_beats = out_beats(64);
        foreach (short_lens[i]) begin
            total_beats += out_beats(short_lens[i]);
        end
        for (int len = 1; len <= 130; len++) begin
            total_beats += out_beats(len);
        end
        foreach (stall_lens[i]) begin
            total_beats += out_beats(stall_lens[i]);
        end
        #(total_beats * 4 * 100 + 2000);
        $display("Timeout: the run did not finish within %0d ns", total_beats * 4 * 100 + 2000);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_beat    = '0;
        out_credit = 1'b0;
        check_reset();
        pass_64_byte_packet();
        pad_short_packets();
        sweep_lengths();
        stall_output();
        count_input_credits();
        $display("Tests passed: %0d, failed: %0d, errors: %0d", test_passes, test_fails, errors);
        if (test_fails == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/pkt_stream_pkg.sv
rtl/credit_pkg.sv
rtl/pkt_ingress_buffer.sv
rtl/pkt_pad.sv
rtl/pkt_egress_credit.sv
rtl/pkt_pad_top.sv
verification/tb_pkt_pad_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pkt_pad_top
FILE_LIST ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
